/* sim.f */
source/csr_arch_pkg.sv
source/commit_pkg.sv
source/stage_if.sv
source/stage_reg.sv
source/commit_decode.sv
source/csr_file.sv
source/commit_result.sv
source/commit_top.sv
testbench/commit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= commit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^TEST OK$$'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/commit_tb.sv */
module commit_tb
    import csr_arch_pkg::*;
    import commit_pkg::*;
;

    logic                 clk;
    logic                 resetn;
    logic                 in_valid;
    logic                 in_allowin;
    logic [31:0]          in_pc;
    logic                 in_rf_we;
    logic [RF_ADDR_W-1:0] in_rf_waddr;
    logic [31:0]          in_rf_result;
    logic                 in_csr_rd;
    csr_num_t             in_csr_num;
    logic                 in_csr_we;
    logic [31:0]          in_csr_wmask;
    logic [31:0]          in_csr_wvalue;
    logic                 in_ertn;
    logic                 in_excp_adef;
    logic                 in_excp_ine;
    logic                 in_excp_syscall;
    logic                 in_excp_brk;
    logic                 in_excp_ale;
    logic [31:0]          in_vaddr;
    logic                 out_valid;
    logic                 out_ready;
    logic [31:0]          out_pc;
    logic                 out_rf_we;
    logic [RF_ADDR_W-1:0] out_rf_waddr;
    logic [31:0]          out_rf_wdata;
    ecode_t               out_ecode;
    logic                 flush;
    logic [31:0]          flush_target;

    integer      seed = 32'h3822_6b78;
    string       cur_test;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errs;
    logic        hung;
    logic        bp_on;
    commit_t     exp_q[$];
    logic [31:0] redir_q[$];

    // reference copies of the CSRs
    logic [31:0] m_crmd, m_prmd, m_estat, m_era, m_badv, m_eentry;
    logic [31:0] m_save [4];

    csr_num_t csr_list [11] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, 14'h3ff};

    commit_top #(.DATA_W(32)) commit_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic logic [31:0] writable(csr_num_t num);
        case (num)
            CSR_CRMD, CSR_PRMD: return 32'h0000_0007;
            CSR_ESTAT:          return 32'h0000_0003;
            CSR_EENTRY:         return 32'hffff_ffc0;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return 32'hffff_ffff;
            default:            return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(csr_num_t num);
        case (num)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ESTAT:  return m_estat;
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            default:    return 32'h0;
        endcase
    endfunction

    // one retiring instruction in acceptance order
    task automatic model_apply(input retire_t r);
        commit_t     c;
        ecode_t      ec;
        logic        ex;
        logic [31:0] old, wm, nv;
        ex = |r.excp;
        ec = r.excp.adef ? ECODE_ADE : r.excp.ine ? ECODE_INE : r.excp.syscall ? ECODE_SYS :
             r.excp.brk ? ECODE_BRK : r.excp.ale ? ECODE_ALE : 6'h0;
        old = model_read(r.csr_num);
        c.pc       = r.pc;
        c.rf_we    = r.rf_we && !ex;
        c.rf_waddr = r.rf_waddr;
        c.rf_wdata = r.csr_rd ? old : r.rf_result;
        c.ecode    = ec;
        exp_q.push_back(c);
        if (r.csr_we && !ex) begin
            wm = r.csr_wmask & writable(r.csr_num);
            nv = (old & ~wm) | (r.csr_wvalue & wm);
            case (r.csr_num)
                CSR_CRMD:   m_crmd   = nv;
                CSR_PRMD:   m_prmd   = nv;
                CSR_ESTAT:  m_estat  = nv;
                CSR_ERA:    m_era    = nv;
                CSR_BADV:   m_badv   = nv;
                CSR_EENTRY: m_eentry = nv;
                CSR_SAVE0:  m_save[0] = nv;
                CSR_SAVE1:  m_save[1] = nv;
                CSR_SAVE2:  m_save[2] = nv;
                CSR_SAVE3:  m_save[3] = nv;
                default:    ;
            endcase
        end
        if (ex) begin
            redir_q.push_back(m_eentry);
            m_prmd[2:0]    = m_crmd[2:0];
            m_crmd[2:0]    = 3'b000;
            m_estat[21:16] = ec;
            m_era          = r.pc;
            if (r.excp.adef || r.excp.ale) begin
                m_badv = r.vaddr;
            end
        end else if (r.ertn) begin
            redir_q.push_back(m_era);
            m_crmd[2:0] = m_prmd[2:0];
        end
    endtask

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_redirect(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected target %h actual target %h", name, exp, act);
        end
    endtask

    // compare process, sampled on the edge so all values are pre-update
    always @(posedge clk) begin
        retire_t r;
        commit_t act;
        if (resetn) begin
            if (in_valid && in_allowin && !flush) begin
                r = '0;
                r.pc = in_pc;
                r.rf_we = in_rf_we;
                r.rf_waddr = in_rf_waddr;
                r.rf_result = in_rf_result;
                r.csr_rd = in_csr_rd;
                r.csr_num = in_csr_num;
                r.csr_we = in_csr_we;
                r.csr_wmask = in_csr_wmask;
                r.csr_wvalue = in_csr_wvalue;
                r.ertn = in_ertn;
                r.excp = {in_excp_adef, in_excp_ine, in_excp_syscall, in_excp_brk, in_excp_ale};
                r.vaddr = in_vaddr;
                model_apply(r);
            end
            if (flush) begin
                if (redir_q.size() == 0) begin
                    errors++;
                    $display("%s: flush to %h that no instruction asked for", cur_test,
                             flush_target);
                end else begin
                    check_redirect(cur_test, redir_q.pop_front(), flush_target);
                end
            end
            if (out_valid && out_ready) begin
                act = '{out_pc, out_rf_we, out_rf_waddr, out_rf_wdata, out_ecode};
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: unexpected output with pc %h", cur_test, out_pc);
                end else begin
                    check_commit(cur_test, exp_q.pop_front(), act);
                end
            end
            if (out_rf_we && !(out_valid && out_ready)) begin
                errors++;
                $display("%s: register write enable high without an accepted output",
                         cur_test);
            end
        end
    end

    always @(posedge clk) begin
        if (bp_on) begin
            out_ready <= rnd() % 3 != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    task automatic send(input retire_t r);
        int t;
        in_valid <= 1'b1;
        in_pc <= r.pc;
        in_rf_we <= r.rf_we;
        in_rf_waddr <= r.rf_waddr;
        in_rf_result <= r.rf_result;
        in_csr_rd <= r.csr_rd;
        in_csr_num <= r.csr_num;
        in_csr_we <= r.csr_we;
        in_csr_wmask <= r.csr_wmask;
        in_csr_wvalue <= r.csr_wvalue;
        in_ertn <= r.ertn;
        {in_excp_adef, in_excp_ine, in_excp_syscall, in_excp_brk, in_excp_ale} <= r.excp;
        in_vaddr <= r.vaddr;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!in_allowin && t < 100 && !hung);
        if (!in_allowin && !hung) begin
            hung = 1'b1;
            $display("timeout: %s, input never accepted", cur_test);
        end
    endtask

    task automatic idle();
        in_valid <= 1'b0;
    endtask

    // kind 0 plain, 1 csr access, 2 exception, 3 ertn
    task automatic make_instr(input int kind, input csr_num_t num, output retire_t r);
        logic [31:0] v;
        r = '0;
        v = rnd();
        r.pc = {v[31:2], 2'b00};
        v = rnd();
        r.rf_we = v[0];
        r.rf_waddr = v[12:8];
        r.rf_result = rnd();
        r.vaddr = rnd();
        r.csr_num = num;
        if (kind == 1) begin
            r.csr_rd = v[16];
            r.csr_we = v[17] || !v[16];
            r.csr_wmask = rnd();
            r.csr_wvalue = rnd();
        end else if (kind == 2) begin
            r.excp = (v[24:20] == 5'b0) ? 5'b00100 : v[24:20];
            r.csr_rd = v[25];
            r.csr_we = v[26];
            r.ertn = v[27];
        end else if (kind == 3) begin
            r.ertn = 1'b1;
        end
    endtask

    task automatic send_read(input csr_num_t num);
        retire_t r;
        make_instr(0, num, r);
        r.csr_rd = 1'b1;
        send(r);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while ((exp_q.size() != 0 || redir_q.size() != 0) && t < 500 && !hung) begin
            @(posedge clk);
            t++;
        end
        if (t >= 500) begin
            hung = 1'b1;
            $display("timeout: %s, outputs still missing", cur_test);
        end
    endtask

    task automatic end_test();
        idle();
        drain();
        tests_run++;
        if (errors != test_errs || hung) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", cur_test, (errors == test_errs && !hung) ? "passed" :
                 "failed", errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        retire_t r;
        int      n;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errs = 0;
        hung = 1'b0;
        bp_on = 1'b0;
        cur_test = "reset";
        m_crmd = '0;
        m_prmd = '0;
        m_estat = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = EENTRY_RESET;
        m_save = '{default: '0};
        resetn = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_rf_we = 1'b0;
        in_rf_waddr = '0;
        in_rf_result = '0;
        in_csr_rd = 1'b0;
        in_csr_num = '0;
        in_csr_we = 1'b0;
        in_csr_wmask = '0;
        in_csr_wvalue = '0;
        in_ertn = 1'b0;
        {in_excp_adef, in_excp_ine, in_excp_syscall, in_excp_brk, in_excp_ale} = '0;
        in_vaddr = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        checks++;
        if (out_valid || flush || out_rf_we || !in_allowin) begin
            errors++;
            $display("%s: handshake or trace outputs not idle after reset", cur_test);
        end
        end_test();

        cur_test = "plain_writeback";
        make_instr(0, CSR_SAVE0, r);
        send(r);
        idle();
        n = 0;
        while (!out_valid && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (n != 2) begin
            errors++;
            $display("error %s: expected latency 2 actual latency %0d", cur_test, n);
        end
        for (int i = 0; i < 20; i++) begin
            make_instr(0, CSR_SAVE0, r);
            send(r);
        end
        end_test();

        cur_test = "masked_csr";
        for (int i = 0; i < 30; i++) begin
            make_instr(1, csr_list[5 + rnd() % 5], r);
            send(r);
        end
        end_test();

        cur_test = "exception_entry";
        for (int i = 0; i < 10; i++) begin
            make_instr(2, CSR_SAVE1, r);
            send(r);
            // younger one lands in the flush cycle
            make_instr(0, CSR_SAVE1, r);
            send(r);
            send_read(CSR_ERA);
            send_read(CSR_BADV);
            send_read(CSR_ESTAT);
            send_read(CSR_PRMD);
        end
        end_test();

        cur_test = "ertn_return";
        for (int i = 0; i < 8; i++) begin
            make_instr(1, CSR_PRMD, r);
            r.csr_we = 1'b1;
            send(r);
            make_instr(3, CSR_CRMD, r);
            send(r);
            make_instr(0, CSR_CRMD, r);
            send(r);
            send_read(CSR_CRMD);
        end
        end_test();

        cur_test = "backpressure";
        bp_on = 1'b1;
        for (int i = 0; i < 80; i++) begin
            make_instr(rnd() % 4, csr_list[rnd() % 11], r);
            send(r);
        end
        for (int i = 0; i < 11; i++) begin
            send_read(csr_list[i]);
        end
        end_test();
        bp_on = 1'b0;

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* source/commit_top.sv */
module commit_top
    import csr_arch_pkg::*;
    import commit_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    output logic                 in_allowin,
    input  logic [31:0]          in_pc,
    input  logic                 in_rf_we,
    input  logic [RF_ADDR_W-1:0] in_rf_waddr,
    input  logic [DATA_W-1:0]    in_rf_result,
    input  logic                 in_csr_rd,
    input  csr_num_t             in_csr_num,
    input  logic                 in_csr_we,
    input  logic [31:0]          in_csr_wmask,
    input  logic [31:0]          in_csr_wvalue,
    input  logic                 in_ertn,
    input  logic                 in_excp_adef,
    input  logic                 in_excp_ine,
    input  logic                 in_excp_syscall,
    input  logic                 in_excp_brk,
    input  logic                 in_excp_ale,
    input  logic [31:0]          in_vaddr,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [31:0]          out_pc,
    output logic                 out_rf_we,
    output logic [RF_ADDR_W-1:0] out_rf_waddr,
    output logic [DATA_W-1:0]    out_rf_wdata,
    output ecode_t               out_ecode,
    output logic                 flush,
    output logic [31:0]          flush_target
);

    retire_t in_instr;

    always_comb begin
        in_instr.pc           = in_pc;
        in_instr.rf_we        = in_rf_we;
        in_instr.rf_waddr     = in_rf_waddr;
        in_instr.rf_result    = in_rf_result;
        in_instr.csr_rd       = in_csr_rd;
        in_instr.csr_num      = in_csr_num;
        in_instr.csr_we       = in_csr_we;
        in_instr.csr_wmask    = in_csr_wmask;
        in_instr.csr_wvalue   = in_csr_wvalue;
        in_instr.ertn         = in_ertn;
        in_instr.excp.adef    = in_excp_adef;
        in_instr.excp.ine     = in_excp_ine;
        in_instr.excp.syscall = in_excp_syscall;
        in_instr.excp.brk     = in_excp_brk;
        in_instr.excp.ale     = in_excp_ale;
        in_instr.vaddr        = in_vaddr;
    end

    stage_if #(.payload_t(csr_cmd_t)) dec_if ();
    stage_if #(.payload_t(csr_cmd_t)) exe_if ();
    stage_if #(.payload_t(commit_t))  res_if ();
    stage_if #(.payload_t(commit_t))  out_if ();

    commit_decode commit_decode_inst (
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_instr   (in_instr),
        .dn         (dec_if.sender)
    );

    stage_reg #(.payload_t(csr_cmd_t)) dec_reg_inst (
        .clk    (clk),
        .resetn (resetn),
        .up     (dec_if.receiver),
        .dn     (exe_if.sender)
    );

    csr_file #(.DATA_W(DATA_W)) csr_file_inst (
        .clk          (clk),
        .resetn       (resetn),
        .up           (exe_if.receiver),
        .dn           (res_if.sender),
        .flush        (flush),
        .flush_target (flush_target)
    );

    stage_reg #(.payload_t(commit_t)) res_reg_inst (
        .clk    (clk),
        .resetn (resetn),
        .up     (res_if.receiver),
        .dn     (out_if.sender)
    );

    commit_result #(.DATA_W(DATA_W)) commit_result_inst (
        .up           (out_if.receiver),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_rf_we    (out_rf_we),
        .out_rf_waddr (out_rf_waddr),
        .out_rf_wdata (out_rf_wdata),
        .out_ecode    (out_ecode)
    );

endmodule

/* source/commit_result.sv */
module commit_result
    import csr_arch_pkg::*;
    import commit_pkg::*;
#(
    parameter int DATA_W = 32
) (
    stage_if.receiver            up,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [31:0]          out_pc,
    output logic                 out_rf_we,
    output logic [RF_ADDR_W-1:0] out_rf_waddr,
    output logic [DATA_W-1:0]    out_rf_wdata,
    output ecode_t               out_ecode
);

    commit_t res;
    logic    accept;

    assign res    = up.payload;
    assign accept = up.valid && out_ready;

    // write only lands on the handshake cycle
    assign out_rf_we    = accept && res.rf_we;
    assign out_valid    = up.valid;
    assign out_pc       = res.pc;
    assign out_rf_waddr = res.rf_waddr;
    assign out_rf_wdata = res.rf_wdata;
    assign out_ecode    = res.ecode;

    assign up.allowin = !up.valid || out_ready;
    // last stage, nothing further down ever flushes
    assign up.kill    = 1'b0;

endmodule

/* source/csr_file.sv */
module csr_file
    import csr_arch_pkg::*;
    import commit_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic        clk,
    input  logic        resetn,
    stage_if.receiver   up,
    stage_if.sender     dn,
    output logic        flush,
    output logic [31:0] flush_target
);

    csr_cmd_t          cmd;
    commit_t           res;
    logic              advance;
    logic [DATA_W-1:0] crmd_q;
    logic [DATA_W-1:0] prmd_q;
    logic [DATA_W-1:0] estat_q;
    logic [DATA_W-1:0] era_q;
    logic [DATA_W-1:0] badv_q;
    logic [DATA_W-1:0] eentry_q;
    logic [DATA_W-1:0] save_q [4];
    logic [DATA_W-1:0] rd_value;
    logic [DATA_W-1:0] wr_mask;
    logic [DATA_W-1:0] wr_value;

    assign cmd     = up.payload;
    assign advance = up.valid && dn.allowin;

    always_comb begin
        case (cmd.csr_num)
            CSR_CRMD:   rd_value = crmd_q;
            CSR_PRMD:   rd_value = prmd_q;
            CSR_ESTAT:  rd_value = estat_q;
            CSR_ERA:    rd_value = era_q;
            CSR_BADV:   rd_value = badv_q;
            CSR_EENTRY: rd_value = eentry_q;
            CSR_SAVE0:  rd_value = save_q[0];
            CSR_SAVE1:  rd_value = save_q[1];
            CSR_SAVE2:  rd_value = save_q[2];
            CSR_SAVE3:  rd_value = save_q[3];
            default:    rd_value = '0;
        endcase
    end

    // only writable fields take the new bits
    assign wr_mask  = cmd.csr_wmask & csr_wmask_of(cmd.csr_num);
    assign wr_value = (rd_value & ~wr_mask) | (cmd.csr_wvalue & wr_mask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_q   <= '0;
            prmd_q   <= '0;
            estat_q  <= '0;
            era_q    <= '0;
            badv_q   <= '0;
            eentry_q <= EENTRY_RESET;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (advance) begin
            if (cmd.csr_we) begin
                case (cmd.csr_num)
                    CSR_CRMD:   crmd_q    <= wr_value;
                    CSR_PRMD:   prmd_q    <= wr_value;
                    CSR_ESTAT:  estat_q   <= wr_value;
                    CSR_ERA:    era_q     <= wr_value;
                    CSR_BADV:   badv_q    <= wr_value;
                    CSR_EENTRY: eentry_q  <= wr_value;
                    CSR_SAVE0:  save_q[0] <= wr_value;
                    CSR_SAVE1:  save_q[1] <= wr_value;
                    CSR_SAVE2:  save_q[2] <= wr_value;
                    CSR_SAVE3:  save_q[3] <= wr_value;
                    default:    ;
                endcase
            end
            if (cmd.excp) begin
                // save mode, drop to plv0 with interrupts off
                prmd_q[PRMD_PPLV +: 2]    <= crmd_q[CRMD_PLV +: 2];
                prmd_q[PRMD_PIE]          <= crmd_q[CRMD_IE];
                crmd_q[CRMD_PLV +: 2]     <= 2'b00;
                crmd_q[CRMD_IE]           <= 1'b0;
                estat_q[ESTAT_ECODE +: 6] <= cmd.ecode;
                era_q                     <= cmd.pc;
                if (cmd.badv_we) begin
                    badv_q <= cmd.vaddr;
                end
            end else if (cmd.ertn) begin
                crmd_q[CRMD_PLV +: 2] <= prmd_q[PRMD_PPLV +: 2];
                crmd_q[CRMD_IE]       <= prmd_q[PRMD_PIE];
            end
        end
    end

    assign flush        = advance && (cmd.excp || cmd.ertn);
    assign flush_target = !flush   ? '0 :
                          cmd.excp ? eentry_q : era_q;

    always_comb begin
        res.pc       = cmd.pc;
        res.rf_we    = cmd.rf_we;
        res.rf_waddr = cmd.rf_waddr;
        res.rf_wdata = cmd.csr_rd ? rd_value : cmd.rf_result;
        res.ecode    = cmd.ecode;
    end

    assign dn.valid   = up.valid;
    assign dn.payload = res;
    assign up.allowin = dn.allowin;
    // younger instruction entering the decode register dies with the flush
    assign up.kill    = flush || dn.kill;

    // bits above plv and ie never get set in crmd or prmd
    assert property (@(posedge clk) disable iff (!resetn)
        crmd_q[DATA_W-1:3] == '0 && prmd_q[DATA_W-1:3] == '0);

    assert property (@(posedge clk) disable iff (!resetn) flush |=> !up.valid);

endmodule

/* source/commit_decode.sv */
module commit_decode
    import csr_arch_pkg::*;
    import commit_pkg::*;
(
    input  logic    in_valid,
    output logic    in_allowin,
    input  retire_t in_instr,
    stage_if.sender dn
);

    logic     any_excp;
    ecode_t   ecode;
    csr_cmd_t cmd;

    assign any_excp = |in_instr.excp;

    // fixed priority, fetch fault first
    always_comb begin
        if (in_instr.excp.adef) begin
            ecode = ECODE_ADE;
        end else if (in_instr.excp.ine) begin
            ecode = ECODE_INE;
        end else if (in_instr.excp.syscall) begin
            ecode = ECODE_SYS;
        end else if (in_instr.excp.brk) begin
            ecode = ECODE_BRK;
        end else if (in_instr.excp.ale) begin
            ecode = ECODE_ALE;
        end else begin
            ecode = '0;
        end
    end

    always_comb begin
        cmd.pc         = in_instr.pc;
        cmd.rf_waddr   = in_instr.rf_waddr;
        cmd.rf_result  = in_instr.rf_result;
        cmd.csr_rd     = in_instr.csr_rd;
        cmd.csr_num    = in_instr.csr_num;
        cmd.csr_wmask  = in_instr.csr_wmask;
        cmd.csr_wvalue = in_instr.csr_wvalue;
        cmd.vaddr      = in_instr.vaddr;
        cmd.excp       = any_excp;
        cmd.ecode      = ecode;
        // faulting instruction leaves no architectural side effect
        cmd.rf_we      = in_instr.rf_we && !any_excp;
        cmd.csr_we     = in_instr.csr_we && !any_excp;
        // exception wins over ertn
        cmd.ertn       = in_instr.ertn && !any_excp;
        cmd.badv_we    = in_instr.excp.adef || in_instr.excp.ale;
    end

    assign dn.valid    = in_valid;
    assign dn.payload  = cmd;
    assign in_allowin  = dn.allowin;

endmodule

/* source/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic      clk,
    input  logic      resetn,
    stage_if.receiver up,
    stage_if.sender   dn
);

    logic     valid_q;
    payload_t payload_q;

    assign up.allowin = !valid_q || dn.allowin;
    // anything upstream of a flushed slot is younger
    assign up.kill    = dn.kill;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (dn.kill) begin
            valid_q <= 1'b0;
        end else if (up.allowin) begin
            valid_q <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.allowin && !dn.kill) begin
            payload_q <= up.payload;
        end
    end

    assign dn.valid   = valid_q;
    assign dn.payload = payload_q;

    // stalled item must not change under the receiver
    assert property (@(posedge clk) disable iff (!resetn)
        dn.valid && !dn.allowin |=> dn.valid && $stable(dn.payload));

endmodule

/* source/stage_if.sv */
// one pipeline hop, item moves when valid and allowin are both high
interface stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t payload;
    logic     allowin;
    // downstream flush, drops the item held on the sending side
    logic     kill;

    modport sender (
        output valid,
        output payload,
        input  allowin,
        input  kill
    );

    modport receiver (
        input  valid,
        input  payload,
        output allowin,
        output kill
    );

endinterface

/* source/commit_pkg.sv */
package commit_pkg;

    import csr_arch_pkg::*;

    localparam int RF_ADDR_W = 5;
    localparam int RF_DATA_W = 32;

    typedef struct packed {
        logic adef;
        logic ine;
        logic syscall;
        logic brk;
        logic ale;
    } excp_flags_t;

    // instruction as handed over by the memory stage
    typedef struct packed {
        logic [31:0]          pc;
        logic                 rf_we;
        logic [RF_ADDR_W-1:0] rf_waddr;
        logic [RF_DATA_W-1:0] rf_result;
        logic                 csr_rd;
        csr_num_t             csr_num;
        logic                 csr_we;
        logic [31:0]          csr_wmask;
        logic [31:0]          csr_wvalue;
        logic                 ertn;
        excp_flags_t          excp;
        logic [31:0]          vaddr;
    } retire_t;

    typedef struct packed {
        logic [31:0]          pc;
        logic                 rf_we;
        logic [RF_ADDR_W-1:0] rf_waddr;
        logic [RF_DATA_W-1:0] rf_result;
        logic                 csr_rd;
        csr_num_t             csr_num;
        logic                 csr_we;
        logic [31:0]          csr_wmask;
        logic [31:0]          csr_wvalue;
        logic                 ertn;
        logic                 excp;
        ecode_t               ecode;
        logic [31:0]          vaddr;
        logic                 badv_we;
    } csr_cmd_t;

    typedef struct packed {
        logic [31:0]          pc;
        logic                 rf_we;
        logic [RF_ADDR_W-1:0] rf_waddr;
        logic [RF_DATA_W-1:0] rf_wdata;
        ecode_t               ecode;
    } commit_t;

endpackage

/* source/csr_arch_pkg.sv */
package csr_arch_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;

    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;
    localparam ecode_t ECODE_SYS = 6'h0b;
    localparam ecode_t ECODE_BRK = 6'h0c;
    localparam ecode_t ECODE_INE = 6'h0d;

    // low bit of each field
    localparam int CRMD_PLV    = 0;
    localparam int CRMD_IE     = 2;
    localparam int PRMD_PPLV   = 0;
    localparam int PRMD_PIE    = 2;
    localparam int ESTAT_ECODE = 16;

    localparam logic [31:0] EENTRY_RESET = 32'h1c00_0000;

    // software-writable bits, everything else reads as held or zero
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

    function automatic logic [31:0] csr_wmask_of(csr_num_t num);
        case (num)
            CSR_CRMD:   return CRMD_WMASK;
            CSR_PRMD:   return PRMD_WMASK;
            CSR_ESTAT:  return ESTAT_WMASK;
            CSR_EENTRY: return EENTRY_WMASK;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return '1;
            default:    return '0;
        endcase
    endfunction

endpackage
